/* pc_glue.f */
hdl/pc_glue_pkg.sv
hdl/host_bridge.sv
hdl/fb_descriptor.sv
hdl/activity_led.sv
hdl/pc_glue.sv
bench/pc_glue_properties.sv
bench/tb_pc_glue.sv

/* Makefile */
# Verilator lint and simulation for pc_glue

VERILATOR    ?= verilator
TOP          ?= tb_pc_glue
FILELIST     ?= pc_glue.f
BUILD_DIR    ?= obj_dir
PASS_TEXT    ?= ALL TESTS PASSED
COMMON_FLAGS ?= --timing --assert --top-module $(TOP)
LINT_FLAGS   ?= --lint-only -Wall
SIM_FLAGS    ?= --binary -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) $(COMMON_FLAGS) -f $(FILELIST)

# Pass only when the run prints the pass line
sim:
	$(VERILATOR) $(SIM_FLAGS) $(COMMON_FLAGS) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$($(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

/* bench/tb_pc_glue.sv */
// Testbench for pc_glue with bus slave model, reference models, comparison and watchdog
module tb_pc_glue import pc_glue_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD_NS   = 8;
	localparam int LED_HOLD        = 20;
	localparam int NUM_GEOM_TESTS  = 200;
	localparam int NUM_XFER_TESTS  = 16;
	localparam int NUM_TESTS       = NUM_GEOM_TESTS + NUM_XFER_TESTS + 2;
	// An LED run is the longest single test, about 50 cycles
	localparam int CYCLES_PER_TEST = 60;
	localparam int WATCHDOG_NS     = (NUM_TESTS * CYCLES_PER_TEST + 20) * CLK_PERIOD_NS;
	localparam int XFER_TIMEOUT    = 40;

	logic      clk_sys;
	logic      cpu_reset;
	host_req_t host;
	host_cfg_t cfg;
	logic      ext_wait;
	bus_data_t host_rdata;
	bus_req_t  bus_req;
	bus_rsp_t  bus_rsp = '0;
	vga_geom_t geom;
	pal_core_t pal_in;
	logic      disk_device;
	fb_desc_t  desc;
	pal_fb_t   pal_out;
	logic      led_disk;
	logic      led_user;

	integer    seed = 51;
	int        errors = 0;
	int        checks = 0;
	logic      video_check_on = 1'b0;
	logic      led_check_on = 1'b0;
	logic      led_dev = 1'b0;
	vga_geom_t geom_q;
	host_cfg_t cfg_q;

	// Slave side of the management bus
	bus_data_t slave_mem [bus_addr_t];
	int        wait_left = 0;
	int        rd_left = 0;
	bus_data_t rd_value;

	pc_glue #(.LED_HOLD_CYCLES(LED_HOLD)) u_pc_glue (.*);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD_NS / 2) clk_sys = ~clk_sys;
	end

	// ========================================================================
	// Reference models
	// ========================================================================
	function automatic fb_desc_t expected_desc(input vga_geom_t g, input host_cfg_t c);
		fb_desc_t     d;
		logic [1:0]   depth;
		fb_fmt_code_t fmt;
		depth = g.flags[1:0];
		if (depth == DEPTH_24)
			fmt = FMT_24BPP;
		else if (depth == DEPTH_16)
			fmt = FMT_16BPP;
		else
			fmt = FMT_8BPP;
		d.en = !g.flags[2] && (depth != 2'd0);
		d.format = {~c.bgr_order, ~c.fmt_1555, fmt};
		if (depth == DEPTH_24)
			d.width = FB_WIDTH_24;
		else if (g.flags[2])
			d.width = 12'(g.width * 4);
		else
			d.width = 12'(g.width * 8);
		d.height = g.flags[3] ? 12'(g.height / 2) : 12'(g.height);
		d.base = (32'(FB_REGION) << 22) | (32'(g.start_addr) << 2);
		d.stride = 14'(g.stride * 8);
		d.force_blank = g.off;
		return d;
	endfunction

	// Top two bits of each 6-bit channel fill the new low bits
	function automatic pal_fb_t expected_palette(input pal_core_t p);
		pal_fb_t    q;
		logic [5:0] c;
		q.we = p.we;
		q.addr = p.addr;
		for (int ch = 0; ch < 3; ch++) begin
			c = p.data[ch * 6 +: 6];
			q.data[ch * 8 +: 8] = 8'(c) * 8'd4 + 8'(c >> 4);
		end
		return q;
	endfunction

	task automatic check_value(input string name, input logic [127:0] expected,
		input logic [127:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("Mismatch at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
		end
	endtask

	// Called on a rising edge, returns on the first edge that sees ext_wait low
	task automatic host_transfer(input logic is_write, input bus_addr_t addr,
		input bus_data_t data);
		int cycles;
		host.rd    <= !is_write;
		host.wr    <= is_write;
		host.addr  <= addr;
		host.wdata <= data;
		@(posedge clk_sys);
		host.rd <= 1'b0;
		host.wr <= 1'b0;
		cycles = 0;
		do begin
			@(posedge clk_sys);
			cycles++;
		end while (ext_wait && cycles < XFER_TIMEOUT);
		if (ext_wait) begin
			errors++;
			$display("Host transfer to %h did not finish within %0d cycles", addr, cycles);
		end
	endtask

	task automatic led_run(input logic dev);
		int n;
		// Earlier transfers may still hold an LED on
		repeat (LED_HOLD + 4) @(posedge clk_sys);
		disk_device  <= dev;
		led_dev      <= dev;
		led_check_on <= 1'b1;
		@(posedge clk_sys);
		host_transfer(1'b1, 32'h0000_0100, 32'(dev));
		check_value(dev ? "led_disk" : "led_user", 128'(1'b1),
			128'(dev ? led_disk : led_user));
		n = 1;
		while ((led_disk || led_user) && n <= 22) begin
			@(posedge clk_sys);
			n++;
		end
		if (led_disk || led_user) begin
			errors++;
			$display("LED still lit %0d cycles after ext_wait fell", n);
		end
		led_check_on <= 1'b0;
	endtask

	// ========================================================================
	// Comparison
	// ========================================================================
	always @(posedge clk_sys) begin
		if (video_check_on) begin
			check_value("desc", 128'(expected_desc(geom_q, cfg_q)), 128'(desc));
			check_value("pal_out", 128'(expected_palette(pal_in)), 128'(pal_out));
		end
		// The LED of the other device stays dark
		if (led_check_on)
			check_value(led_dev ? "led_user" : "led_disk", 128'(1'b0),
				128'(led_dev ? led_user : led_disk));
		geom_q <= geom;
		cfg_q  <= cfg;
	end

	// Bus slave with random waitrequest stretch and read latency
	always @(posedge clk_sys) begin
		if (cpu_reset) begin
			bus_rsp   <= '0;
			wait_left = 0;
			rd_left   = 0;
		end else begin
			bus_rsp.rdatavalid <= 1'b0;
			if (rd_left != 0) begin
				rd_left = rd_left - 1;
				if (rd_left == 0) begin
					bus_rsp.rdatavalid <= 1'b1;
					bus_rsp.rdata      <= rd_value;
				end
			end
			if ((bus_req.read || bus_req.write) && !bus_rsp.waitrequest) begin
				if (bus_req.write) begin
					slave_mem[bus_req.addr] = bus_req.wdata;
				end else begin
					rd_value = slave_mem.exists(bus_req.addr) ? slave_mem[bus_req.addr] :
						({bus_req.addr[15:0], bus_req.addr[31:16]} ^ 32'h5a5a_a5a5);
					rd_left = 1 + ($random(seed) & 3);
				end
				wait_left = $random(seed) & 3;
				bus_rsp.waitrequest <= (wait_left != 0);
			end else if ((bus_req.read || bus_req.write) && wait_left != 0) begin
				wait_left = wait_left - 1;
				bus_rsp.waitrequest <= (wait_left != 0);
			end
		end
	end

	// ========================================================================
	// Stimulus
	// ========================================================================
	initial begin : stimulus
		bus_addr_t addr;
		bus_data_t data;
		cpu_reset   = 1'b1;
		host        = '0;
		cfg         = '0;
		geom        = '0;
		pal_in      = '0;
		disk_device = 1'b0;
		repeat (10) @(posedge clk_sys);
		cpu_reset <= 1'b0;
		@(posedge clk_sys);
		check_value("ext_wait", 128'(1'b0), 128'(ext_wait));
		check_value("bus_req.read", 128'(1'b0), 128'(bus_req.read));
		check_value("bus_req.write", 128'(1'b0), 128'(bus_req.write));
		check_value("led_disk", 128'(1'b0), 128'(led_disk));
		check_value("led_user", 128'(1'b0), 128'(led_user));
		check_value("desc.en", 128'(1'b0), 128'(desc.en));
		check_value("desc.force_blank", 128'(1'b0), 128'(desc.force_blank));
		video_check_on <= 1'b1;

		repeat (NUM_GEOM_TESTS) begin
			geom   <= 54'({$random(seed), $random(seed)});
			cfg    <= 2'($random(seed));
			pal_in <= 27'($random(seed));
			repeat (2) @(posedge clk_sys);
		end

		repeat (NUM_XFER_TESTS) begin
			addr = $random(seed);
			data = $random(seed);
			disk_device <= 1'($random(seed));
			host_transfer(1'b1, addr, data);
			if (!slave_mem.exists(addr)) begin
				errors++;
				$display("Slave memory has no entry for address %h after the write", addr);
			end else begin
				check_value("slave_mem", 128'(data), 128'(slave_mem[addr]));
			end
			host_transfer(1'b0, addr, 32'h0);
			check_value("host_rdata", 128'(data), 128'(host_rdata));
		end

		led_run(1'b1);
		led_run(1'b0);

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

	initial begin : watchdog
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

/* bench/pc_glue_properties.sv */
// Concurrent assertions on the host handshake and the management bus of host_bridge
module pc_glue_properties import pc_glue_pkg::*; (
	input logic          clk_sys,
	input logic          cpu_reset,
	input host_req_t     host,
	input logic          ext_wait,
	input bus_req_t      bus_req,
	input bus_rsp_t      bus_rsp
);
	timeunit 1ns;
	timeprecision 1ps;

	// One direction at a time on the bus
	assert property (@(posedge clk_sys) disable iff (cpu_reset)
		!(bus_req.read && bus_req.write))
	else $error("Bus read and write are high together");

	// A stalled request keeps address, data and strobes
	assert property (@(posedge clk_sys) disable iff (cpu_reset)
		(bus_req.read || bus_req.write) && bus_rsp.waitrequest |=> $stable(bus_req))
	else $error("Bus request changed while waitrequest was high");

	assert property (@(posedge clk_sys) disable iff (cpu_reset)
		ext_wait |-> !(host.rd || host.wr))
	else $error("Host pulsed a request while ext_wait was high");

endmodule

bind host_bridge pc_glue_properties u_pc_glue_properties (.*);

/* hdl/pc_glue.sv */
// Board glue top level with host bridge, framebuffer descriptor and activity LEDs
module pc_glue import pc_glue_pkg::*; #(
	parameter int unsigned LED_HOLD_CYCLES = 4500000
) (
	input  logic      clk_sys,
	input  logic      cpu_reset,

	// Host controller
	input  host_req_t host,
	input  host_cfg_t cfg,
	output logic      ext_wait,
	output bus_data_t host_rdata,

	// Core management bus
	output bus_req_t  bus_req,
	input  bus_rsp_t  bus_rsp,

	// Core video and disk status
	input  vga_geom_t geom,
	input  pal_core_t pal_in,
	input  logic      disk_device,

	// Scanout and board LEDs
	output fb_desc_t  desc,
	output pal_fb_t   pal_out,
	output logic      led_disk,
	output logic      led_user
);

	logic hdd_active;
	logic fdd_active;

	// ========================================================================
	// Management bridge
	// ========================================================================
	host_bridge u_host_bridge (
		.clk_sys    (clk_sys),
		.cpu_reset  (cpu_reset),
		.host       (host),
		.ext_wait   (ext_wait),
		.host_rdata (host_rdata),
		.bus_req    (bus_req),
		.bus_rsp    (bus_rsp)
	);

	// ========================================================================
	// Video
	// ========================================================================
	fb_descriptor u_fb_descriptor (
		.clk_sys   (clk_sys),
		.cpu_reset (cpu_reset),
		.geom      (geom),
		.cfg       (cfg),
		.pal_in    (pal_in),
		.desc      (desc),
		.pal_out   (pal_out)
	);

	// ========================================================================
	// LEDs
	// ========================================================================
	// Disk LED for hard disk traffic, user LED for floppy
	assign hdd_active = ext_wait & disk_device;
	assign fdd_active = ext_wait & ~disk_device;

	activity_led #(.HOLD_CYCLES(LED_HOLD_CYCLES)) u_led_disk (
		.clk_sys   (clk_sys),
		.cpu_reset (cpu_reset),
		.active    (hdd_active),
		.led       (led_disk)
	);

	activity_led #(.HOLD_CYCLES(LED_HOLD_CYCLES)) u_led_user (
		.clk_sys   (clk_sys),
		.cpu_reset (cpu_reset),
		.active    (fdd_active),
		.led       (led_user)
	);

endmodule

/* hdl/activity_led.sv */
// Retriggerable pulse stretcher driving one activity LED
module activity_led #(
	parameter int unsigned HOLD_CYCLES = 4500000
) (
	input  logic clk_sys,
	input  logic cpu_reset,
	input  logic active,
	output logic led
);

	localparam int unsigned CNT_W = $clog2(HOLD_CYCLES + 1);

	logic [CNT_W-1:0] count;

	// Any activity restarts the hold time
	always_ff @(posedge clk_sys) begin
		if (cpu_reset) begin
			count <= '0;
			led   <= 1'b0;
		end else begin
			if (active)
				count <= CNT_W'(HOLD_CYCLES);
			else if (count != '0)
				count <= count - 1'b1;

			// Registered so short bursts still give a clean pulse
			led <= (count != '0);
		end
	end

endmodule

/* hdl/fb_descriptor.sv */
// Registered framebuffer scanout descriptor and palette widening from 6 to 8 bits
module fb_descriptor import pc_glue_pkg::*; (
	input  logic      clk_sys,
	input  logic      cpu_reset,
	input  vga_geom_t geom,
	input  host_cfg_t cfg,
	input  pal_core_t pal_in,
	output fb_desc_t  desc,
	output pal_fb_t   pal_out
);

	vga_depth_t   depth;
	logic         planar;
	logic         dbl_lines;
	fb_fmt_code_t fmt_code;
	fb_dim_t      width_px;
	fb_dim_t      height_px;
	fb_desc_t     desc_next;

	assign depth     = geom.flags[1:0];
	assign planar    = geom.flags[2];
	assign dbl_lines = geom.flags[3];

	// Extend a 6-bit channel by repeating its top bits
	function automatic logic [7:0] widen6(input logic [5:0] c);
		return {c, c[5:4]};
	endfunction

	// ========================================================================
	// Descriptor fields
	// ========================================================================
	always_comb begin
		unique case (depth)
			DEPTH_24: fmt_code = FMT_24BPP;
			DEPTH_16: fmt_code = FMT_16BPP;
			DEPTH_8:  fmt_code = FMT_8BPP;
			default:  fmt_code = FMT_8BPP;
		endcase
	end

	// Width comes in 8-pixel units, planar modes pack 4 pixels per unit
	always_comb begin
		if (depth == DEPTH_24)
			width_px = FB_WIDTH_24;
		else if (planar)
			width_px = {1'b0, geom.width, 2'b00};
		else
			width_px = {geom.width, 3'b000};
	end

	// Line doubling scans every line twice
	assign height_px = dbl_lines ? {2'b00, geom.height[10:1]} : {1'b0, geom.height};

	always_comb begin
		desc_next.en          = !planar && (depth != 2'd0);
		desc_next.format      = {~cfg.bgr_order, ~cfg.fmt_1555, fmt_code};
		desc_next.width       = width_px;
		desc_next.height      = height_px;
		desc_next.base        = {FB_REGION, geom.start_addr, 2'b00};
		desc_next.stride      = {2'b00, geom.stride, 3'b000};
		desc_next.force_blank = geom.off;
	end

	always_ff @(posedge clk_sys) begin
		if (cpu_reset) begin
			desc.en          <= 1'b0;
			desc.force_blank <= 1'b0;
		end else begin
			desc <= desc_next;
		end
	end

	// ========================================================================
	// Palette
	// ========================================================================
	// Passes straight through, only the colour depth changes
	assign pal_out = '{
		we:   pal_in.we,
		addr: pal_in.addr,
		data: {widen6(pal_in.data[17:12]), widen6(pal_in.data[11:6]),
			widen6(pal_in.data[5:0])}
	};

endmodule

/* hdl/host_bridge.sv */
// Host request to management bus bridge with a single outstanding transfer
module host_bridge import pc_glue_pkg::*; (
	input  logic      clk_sys,
	input  logic      cpu_reset,

	// Host side
	input  host_req_t host,
	output logic      ext_wait,
	output bus_data_t host_rdata,

	// Management bus
	output bus_req_t  bus_req,
	input  bus_rsp_t  bus_rsp
);

	bridge_state_e state;
	logic          bus_read;
	logic          bus_write;
	bus_addr_t     addr_q;
	bus_data_t     wdata_q;

	logic          host_start;
	logic          accepted;
	logic          rd_return;

	// A new request is only taken while idle
	assign host_start = (state == IDLE) && (host.rd || host.wr);

	// Request goes through in the first cycle without waitrequest
	assign accepted = !bus_rsp.waitrequest;

	// Read data only counts once our read has been taken by the core
	assign rd_return = (state == RD_WAIT) && bus_rsp.rdatavalid &&
		(!bus_read || accepted);

	// ========================================================================
	// Control FSM
	// ========================================================================
	always_ff @(posedge clk_sys) begin
		if (cpu_reset) begin
			state     <= IDLE;
			ext_wait  <= 1'b0;
			bus_read  <= 1'b0;
			bus_write <= 1'b0;
		end else begin
			unique case (state)
				IDLE: begin
					// Write wins if both strobes arrive together
					if (host.wr) begin
						ext_wait <= 1'b1;
						state    <= WR_ISSUE;
					end else if (host.rd) begin
						ext_wait <= 1'b1;
						state    <= RD_ISSUE;
					end
				end
				RD_ISSUE: begin
					bus_read <= 1'b1;
					state    <= RD_WAIT;
				end
				RD_WAIT: begin
					// Drop the request once accepted, then wait for data
					if (bus_read && accepted)
						bus_read <= 1'b0;
					if (rd_return) begin
						ext_wait <= 1'b0;
						state    <= IDLE;
					end
				end
				WR_ISSUE: begin
					bus_write <= 1'b1;
					state     <= WR_DONE;
				end
				WR_DONE: begin
					if (accepted) begin
						bus_write <= 1'b0;
						ext_wait  <= 1'b0;
						state     <= IDLE;
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// ========================================================================
	// Address and data path
	// ========================================================================
	always_ff @(posedge clk_sys) begin
		if (host_start) begin
			addr_q  <= host.addr;
			wdata_q <= host.wdata;
		end
		if (rd_return)
			host_rdata <= bus_rsp.rdata;
	end

	// Address and data stay put for the whole transfer
	assign bus_req = '{
		read:  bus_read,
		write: bus_write,
		addr:  addr_q,
		wdata: wdata_q
	};

endmodule

/* hdl/pc_glue_pkg.sv */
// Shared widths, bus, host and video structs, format constants and the bridge state enum
package pc_glue_pkg;

	// ========================================================================
	// Widths
	// ========================================================================
	typedef logic [31:0] bus_addr_t;
	typedef logic [31:0] bus_data_t;
	// Core geometry, in the units the VGA core reports
	typedef logic [19:0] vga_word_addr_t;
	typedef logic [8:0]  vga_units_t;
	typedef logic [10:0] vga_lines_t;
	typedef logic [1:0]  vga_depth_t;
	// Scanout side
	typedef logic [2:0]  fb_fmt_code_t;
	typedef logic [11:0] fb_dim_t;
	typedef logic [13:0] fb_stride_t;
	typedef logic [7:0]  pal_addr_t;

	// ========================================================================
	// Host and management bus
	// ========================================================================
	typedef struct packed {
		logic      rd;
		logic      wr;
		bus_addr_t addr;
		bus_data_t wdata;
	} host_req_t;

	typedef struct packed {
		logic bgr_order;
		logic fmt_1555;
	} host_cfg_t;

	typedef struct packed {
		logic      read;
		logic      write;
		bus_addr_t addr;
		bus_data_t wdata;
	} bus_req_t;

	typedef struct packed {
		logic      waitrequest;
		logic      rdatavalid;
		bus_data_t rdata;
	} bus_rsp_t;

	// ========================================================================
	// Video
	// ========================================================================
	// flags: [1:0] depth, [2] planar, [3] doubled lines
	typedef struct packed {
		vga_word_addr_t start_addr;
		vga_units_t     width;
		vga_units_t     stride;
		vga_lines_t     height;
		logic [3:0]     flags;
		logic           off;
	} vga_geom_t;

	typedef struct packed {
		logic       en;
		logic [4:0] format;
		fb_dim_t    width;
		fb_dim_t    height;
		bus_addr_t  base;
		fb_stride_t stride;
		logic       force_blank;
	} fb_desc_t;

	typedef struct packed {
		logic        we;
		pal_addr_t   addr;
		logic [17:0] data;
	} pal_core_t;

	typedef struct packed {
		logic        we;
		pal_addr_t   addr;
		logic [23:0] data;
	} pal_fb_t;

	// Upper address bits of the framebuffer window in DDR
	localparam logic [9:0] FB_REGION = 10'b0011_111110;

	localparam vga_depth_t DEPTH_8  = 2'd1;
	localparam vga_depth_t DEPTH_16 = 2'd2;
	localparam vga_depth_t DEPTH_24 = 2'd3;

	localparam fb_fmt_code_t FMT_8BPP  = 3'd3;
	localparam fb_fmt_code_t FMT_16BPP = 3'd4;
	localparam fb_fmt_code_t FMT_24BPP = 3'd5;

	localparam fb_dim_t FB_WIDTH_24 = 12'd640;

	typedef enum logic [2:0] {
		IDLE     = 3'd0,
		RD_ISSUE = 3'd1,
		RD_WAIT  = 3'd2,
		WR_ISSUE = 3'd3,
		WR_DONE  = 3'd4
	} bridge_state_e;

endpackage
